// File: common/dht11_pkg.sv
`default_nettype none

package dht11_pkg;

  // Line timing in clock cycles.
  localparam int START_CYCLES    = 40; // Host start pulse.
  localparam int RESPONSE_CYCLES = 16; // Each sensor response phase.
  localparam int BIT_LOW_CYCLES  = 10; // Low lead-in of every bit.
  localparam int BIT_THRESHOLD   = 9;  // High time above this is a 1.
  localparam int TIMEOUT_CYCLES  = 64; // Longest legal line phase.

  localparam int MAX_TRIES  = 3;
  localparam int FIFO_DEPTH = 4;

  // Wishbone word addresses.
  localparam logic ADDR_CONTROL = 1'b0;
  localparam logic ADDR_DATA    = 1'b1;

  typedef logic [15:0] reading_t;

  // One finished measurement.
  typedef struct packed {
    reading_t humidity;
    reading_t temperature;
    logic     failed;
  } sample_t;

endpackage

`default_nettype wire

// File: common/sample_if.sv
`timescale 1ns/10ps
`default_nettype none

interface sample_if #(
  parameter type payload_t = dht11_pkg::sample_t
) ();

  logic     valid;
  logic     ready;
  payload_t data;

  // Transfer on a rising edge with valid and ready both high.
  modport source (
    output valid,
    output data,
    input  ready
  );

  modport sink (
    input  valid,
    input  data,
    output ready
  );

endinterface

`default_nettype wire

// File: dht11/dht11_control.sv
`timescale 1ns/10ps
`default_nettype none

module dht11_control (
  input  logic clock,
  input  logic reset,
  input  logic measure_request,
  input  logic delay_done,
  input  logic field_ok,
  input  logic field_done,
  input  logic timed_out,
  input  logic tries_done,
  input  logic record_ready,
  output logic start_attempt,
  output logic count_delay,
  output logic count_timeout,
  output logic clear_tries,
  output logic count_try,
  output logic load_temperature,
  output logic load_humidity,
  output logic record_valid,
  output logic record_failed,
  output logic busy
);

  typedef enum logic [3:0] {
    IDLE,
    ATTEMPT,
    START_DELAY,
    WAIT_TEMPERATURE,
    STORE_TEMPERATURE,
    WAIT_HUMIDITY,
    STORE_HUMIDITY,
    DONE,
    RETRY_CHECK,
    FINAL_ERROR
  } state_t;

  state_t state;
  state_t next_state;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      IDLE: if (measure_request) next_state = ATTEMPT;
      ATTEMPT: next_state = START_DELAY;
      START_DELAY: if (delay_done) next_state = WAIT_TEMPERATURE;
      WAIT_TEMPERATURE: begin
        if (timed_out) next_state = RETRY_CHECK;
        else if (field_done) next_state = field_ok ? STORE_TEMPERATURE : RETRY_CHECK;
      end
      STORE_TEMPERATURE: next_state = WAIT_HUMIDITY;
      WAIT_HUMIDITY: begin
        if (timed_out) next_state = RETRY_CHECK;
        else if (field_done) next_state = field_ok ? STORE_HUMIDITY : RETRY_CHECK;
      end
      STORE_HUMIDITY: next_state = DONE;
      DONE: if (record_ready) next_state = IDLE; // Held while the FIFO is full.
      RETRY_CHECK: next_state = tries_done ? FINAL_ERROR : ATTEMPT;
      FINAL_ERROR: if (record_ready) next_state = IDLE;
      default: next_state = IDLE;
    endcase
  end

  assign start_attempt    = (state == ATTEMPT);
  assign count_delay      = (state == START_DELAY);
  assign count_timeout    = (state == WAIT_TEMPERATURE) || (state == WAIT_HUMIDITY);
  assign clear_tries      = (state == IDLE);
  assign count_try        = (state == RETRY_CHECK);
  assign load_temperature = (state == STORE_TEMPERATURE);
  assign load_humidity    = (state == STORE_HUMIDITY);
  assign record_valid     = (state == DONE) || (state == FINAL_ERROR);
  assign record_failed    = (state == FINAL_ERROR);
  assign busy             = (state != IDLE);

endmodule

`default_nettype wire

// File: dht11/dht11_receiver.sv
`timescale 1ns/10ps
`default_nettype none

module dht11_receiver (
  input  logic clock,
  input  logic reset,
  input  logic start_attempt,
  input  logic count_delay,
  input  logic count_timeout,
  input  logic clear_tries,
  input  logic count_try,
  input  logic line_in,
  output logic line_drive_low,
  output logic delay_done,
  output logic field_ok,
  output logic field_done,
  output logic timed_out,
  output logic tries_done,
  output dht11_pkg::reading_t field_data
);

  import dht11_pkg::*;

  typedef enum logic [2:0] {
    RX_IDLE,
    RX_RELEASE,
    RX_RESPONSE_WAIT,
    RX_RESPONSE_LOW,
    RX_RESPONSE_HIGH,
    RX_BIT_LOW,
    RX_BIT_HIGH
  } rx_state_t;

  rx_state_t rx_state;
  logic line_meta;
  logic line_sync;
  logic line_prev;
  logic line_rise;
  logic line_fall;
  logic [$clog2(START_CYCLES)-1:0] delay_count;
  logic [$clog2(TIMEOUT_CYCLES+1)-1:0] phase_count;
  logic [1:0] try_count;
  logic [4:0] bit_count;
  logic [23:0] shift_reg;
  logic [23:0] field_word;
  logic [7:0] checksum;
  logic bit_value;
  logic response_bad;

  // Line idles high through the pull-up.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      line_meta <= 1'b1;
      line_sync <= 1'b1;
      line_prev <= 1'b1;
    end else begin
      line_meta <= line_in;
      line_sync <= line_meta;
      line_prev <= line_sync;
    end
  end

  assign line_rise = line_sync && !line_prev;
  assign line_fall = !line_sync && line_prev;

  assign line_drive_low = count_delay;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      delay_count <= '0;
    end else if (count_delay) begin
      delay_count <= delay_count + 1'b1;
    end else begin
      delay_count <= '0;
    end
  end

  assign delay_done = count_delay && (delay_count == START_CYCLES - 1);

  // Cycles since the last line edge, saturating.
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      phase_count <= '0;
    end else if (start_attempt || line_rise || line_fall) begin
      phase_count <= '0;
    end else if (count_timeout && (phase_count != '1)) begin
      phase_count <= phase_count + 1'b1;
    end
  end

  assign timed_out = count_timeout && (phase_count >= TIMEOUT_CYCLES);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      try_count <= '0;
    end else if (clear_tries) begin
      try_count <= '0;
    end else if (count_try) begin
      try_count <= try_count + 1'b1;
    end
  end

  assign tries_done = (try_count == 2'(MAX_TRIES - 1));

  assign bit_value  = (phase_count > BIT_THRESHOLD);
  assign field_word = {shift_reg[22:0], bit_value};
  assign checksum   = field_word[23:16] + field_word[15:8]; // Modulo 256.

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      rx_state     <= RX_IDLE;
      bit_count    <= '0;
      response_bad <= 1'b0;
      field_done   <= 1'b0;
      field_ok     <= 1'b0;
    end else begin
      field_done <= 1'b0;
      if (start_attempt) begin
        rx_state     <= RX_RELEASE;
        bit_count    <= '0;
        response_bad <= 1'b0;
        field_ok     <= 1'b0;
      end else begin
        case (rx_state)
          RX_RELEASE: if (line_rise) rx_state <= RX_RESPONSE_WAIT; // End of host pulse.
          RX_RESPONSE_WAIT: if (line_fall) rx_state <= RX_RESPONSE_LOW;
          RX_RESPONSE_LOW: begin
            if (line_rise) begin
              if (phase_count < RESPONSE_CYCLES / 2) response_bad <= 1'b1;
              rx_state <= RX_RESPONSE_HIGH;
            end
          end
          RX_RESPONSE_HIGH: begin
            if (line_fall) begin
              if (phase_count < RESPONSE_CYCLES / 2) response_bad <= 1'b1;
              rx_state <= RX_BIT_LOW;
            end
          end
          RX_BIT_LOW: if (line_rise) rx_state <= RX_BIT_HIGH;
          RX_BIT_HIGH: begin
            if (line_fall) begin
              rx_state <= RX_BIT_LOW;
              if (bit_count == 5'd23) begin
                bit_count  <= '0;
                field_done <= 1'b1;
                field_ok   <= (checksum == field_word[7:0]) && !response_bad;
              end else begin
                bit_count <= bit_count + 5'd1;
              end
            end
          end
          default: rx_state <= RX_IDLE;
        endcase
      end
    end
  end

  always_ff @(posedge clock) begin
    if ((rx_state == RX_BIT_HIGH) && line_fall && !start_attempt) begin
      shift_reg <= field_word;
      if (bit_count == 5'd23) field_data <= field_word[23:8];
    end
  end

endmodule

`default_nettype wire

// File: dht11/dht11_interface.sv
`timescale 1ns/10ps
`default_nettype none

module dht11_interface (
  input  logic     clock,
  input  logic     reset,
  input  logic     measure_request,
  output logic     busy,
  input  logic     line_in,
  output logic     line_drive_low,
  sample_if.source samples
);

  import dht11_pkg::*;

  logic start_attempt;
  logic count_delay;
  logic count_timeout;
  logic clear_tries;
  logic count_try;
  logic delay_done;
  logic field_ok;
  logic field_done;
  logic timed_out;
  logic tries_done;
  logic load_temperature;
  logic load_humidity;
  logic record_valid;
  logic record_failed;
  reading_t field_data;
  reading_t temperature;
  reading_t humidity;

  dht11_control control_i (
    .clock            (clock),
    .reset            (reset),
    .measure_request  (measure_request),
    .delay_done       (delay_done),
    .field_ok         (field_ok),
    .field_done       (field_done),
    .timed_out        (timed_out),
    .tries_done       (tries_done),
    .record_ready     (samples.ready),
    .start_attempt    (start_attempt),
    .count_delay      (count_delay),
    .count_timeout    (count_timeout),
    .clear_tries      (clear_tries),
    .count_try        (count_try),
    .load_temperature (load_temperature),
    .load_humidity    (load_humidity),
    .record_valid     (record_valid),
    .record_failed    (record_failed),
    .busy             (busy)
  );

  dht11_receiver receiver_i (
    .clock          (clock),
    .reset          (reset),
    .start_attempt  (start_attempt),
    .count_delay    (count_delay),
    .count_timeout  (count_timeout),
    .clear_tries    (clear_tries),
    .count_try      (count_try),
    .line_in        (line_in),
    .line_drive_low (line_drive_low),
    .delay_done     (delay_done),
    .field_ok       (field_ok),
    .field_done     (field_done),
    .timed_out      (timed_out),
    .tries_done     (tries_done),
    .field_data     (field_data)
  );

  always_ff @(posedge clock) begin
    if (load_temperature) temperature <= field_data;
    if (load_humidity) humidity <= field_data;
  end

  // A failed record reports zero readings.
  assign samples.valid = record_valid;
  assign samples.data  = '{humidity:    record_failed ? '0 : humidity,
                           temperature: record_failed ? '0 : temperature,
                           failed:      record_failed};

endmodule

`default_nettype wire

// File: verilog/sample_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module sample_fifo #(
  parameter type payload_t = dht11_pkg::sample_t
) (
  input  logic       clock,
  input  logic       reset,
  sample_if.sink     push,
  sample_if.source   pop,
  output logic [2:0] count
);

  import dht11_pkg::*;

  payload_t entries [FIFO_DEPTH];
  logic [$clog2(FIFO_DEPTH)-1:0] write_ptr;
  logic [$clog2(FIFO_DEPTH)-1:0] read_ptr;
  logic push_fire;
  logic pop_fire;

  assign push.ready = (count != 3'(FIFO_DEPTH));
  assign pop.valid  = (count != 3'd0);
  assign pop.data   = entries[read_ptr];

  assign push_fire = push.valid && push.ready;
  assign pop_fire  = pop.valid && pop.ready;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      write_ptr <= '0;
      read_ptr  <= '0;
      count     <= 3'd0;
    end else begin
      if (push_fire) write_ptr <= write_ptr + 1'b1; // Pointers wrap at the depth.
      if (pop_fire) read_ptr <= read_ptr + 1'b1;
      if (push_fire && !pop_fire) begin
        count <= count + 3'd1;
      end else if (!push_fire && pop_fire) begin
        count <= count - 3'd1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (push_fire) entries[write_ptr] <= push.data;
  end

endmodule

`default_nettype wire

// File: verilog/wb_sensor_port.sv
`timescale 1ns/10ps
`default_nettype none

module wb_sensor_port (
  input  logic        clock,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic        wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  sample_if.sink      records,
  input  logic [2:0]  count,
  input  logic        busy,
  output logic        measure_request
);

  import dht11_pkg::*;

  logic request;
  logic read_data;
  logic write_control;
  logic pop_pending;
  logic head_failed;
  logic [31:0] status_word;
  logic [31:0] data_word;

  // New cycle seen while no ack is out.
  assign request       = wb_cyc && wb_stb && !wb_ack;
  assign read_data     = request && !wb_we && (wb_adr == ADDR_DATA);
  assign write_control = request && wb_we && (wb_adr == ADDR_CONTROL);

  assign head_failed = records.valid && records.data.failed;
  assign status_word = {27'd0, count, head_failed, busy};
  assign data_word   = records.valid ? {records.data.humidity, records.data.temperature}
                                     : 32'd0;

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      wb_ack          <= 1'b0;
      measure_request <= 1'b0;
      pop_pending     <= 1'b0;
    end else begin
      wb_ack          <= request;
      measure_request <= write_control && wb_dat_w[0];
      pop_pending     <= read_data && records.valid; // Empty reads pop nothing.
    end
  end

  always_ff @(posedge clock) begin
    if (request && !wb_we) begin
      wb_dat_r <= (wb_adr == ADDR_DATA) ? data_word : status_word;
    end
  end

  // High only in the ack cycle of a data read.
  assign records.ready = pop_pending;

endmodule

`default_nettype wire

// File: verilog/dht11_top.sv
`timescale 1ns/10ps
`default_nettype none

module dht11_top (
  input  logic        clock,
  input  logic        reset,
  input  logic        wb_cyc,
  input  logic        wb_stb,
  input  logic        wb_we,
  input  logic        wb_adr,
  input  logic [31:0] wb_dat_w,
  output logic [31:0] wb_dat_r,
  output logic        wb_ack,
  output logic        line_drive_low,
  input  logic        line_in
);

  logic measure_request;
  logic busy;
  logic [2:0] fifo_count;

  sample_if producer_link ();
  sample_if bus_link ();

  dht11_interface producer_i (
    .clock           (clock),
    .reset           (reset),
    .measure_request (measure_request),
    .busy            (busy),
    .line_in         (line_in),
    .line_drive_low  (line_drive_low),
    .samples         (producer_link.source)
  );

  sample_fifo buffer_i (
    .clock (clock),
    .reset (reset),
    .push  (producer_link.sink),
    .pop   (bus_link.source),
    .count (fifo_count)
  );

  wb_sensor_port port_i (
    .clock           (clock),
    .reset           (reset),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .records         (bus_link.sink),
    .count           (fifo_count),
    .busy            (busy),
    .measure_request (measure_request)
  );

endmodule

`default_nettype wire

// File: test/dht11_sensor_model.sv
`timescale 1ns/10ps
`default_nettype none

module dht11_sensor_model (
  input  logic        clock,
  input  logic        line,
  input  logic [15:0] humidity,
  input  logic [15:0] temperature,
  input  logic [2:0]  bad_attempts,
  input  logic        silent,
  input  logic        clear_count,
  output logic        pull_low,
  output int          start_count
);

  import dht11_pkg::*;

  localparam int ONE_HIGH_CYCLES   = 16;
  localparam int ZERO_HIGH_CYCLES  = 4;
  localparam int TURNAROUND_CYCLES = 4;

  int attempt;

  task automatic tick();
    @(posedge clock);
    if (clear_count) start_count <= 0;
  endtask

  // Drive one line level for a number of cycles.
  task automatic hold(input logic low, input int cycles);
    pull_low <= low;
    repeat (cycles) tick();
  endtask

  task automatic send_field(input logic [15:0] value, input logic corrupt);
    logic [7:0]  sum;
    logic [23:0] field;
    sum   = value[15:8] + value[7:0];
    field = {value, corrupt ? ~sum : sum};
    for (int i = 23; i >= 0; i--) begin
      hold(1'b1, BIT_LOW_CYCLES);
      hold(1'b0, field[i] ? ONE_HIGH_CYCLES : ZERO_HIGH_CYCLES);
    end
  endtask

  initial begin
    pull_low    = 1'b0;
    start_count = 0;
    forever begin
      while (line !== 1'b0) tick(); // Host start pulse.
      while (line !== 1'b1) tick(); // Host lets go.
      attempt = start_count + 1;
      start_count <= attempt;
      if (!silent) begin
        hold(1'b0, TURNAROUND_CYCLES);
        hold(1'b1, RESPONSE_CYCLES);
        hold(1'b0, RESPONSE_CYCLES);
        send_field(temperature, 1'b0);
        // Bad checksum on the last field of the first attempts.
        send_field(humidity, attempt <= bad_attempts);
        hold(1'b1, BIT_LOW_CYCLES);
        hold(1'b0, 1);
      end
    end
  end

endmodule

`default_nettype wire

// File: test/dht11_tb.sv
`timescale 1ns/10ps
`default_nettype none

module dht11_tb;

  import dht11_pkg::*;

  localparam int ACK_LIMIT  = 16;
  localparam int ACK_EDGES  = 2; // Request seen on the first edge, ack on the second.
  localparam int POLL_LIMIT = 3000;
  localparam int HOLD_POLLS = 700;

  logic        clock;
  logic        reset;
  logic        wb_cyc;
  logic        wb_stb;
  logic        wb_we;
  logic        wb_adr;
  logic [31:0] wb_dat_w;
  logic [31:0] wb_dat_r;
  logic        wb_ack;
  logic        line_drive_low;
  logic        line_in;
  logic        sensor_low;
  logic [15:0] humidity;
  logic [15:0] temperature;
  logic [2:0]  bad_attempts;
  logic        silent;
  logic        clear_count;
  int          start_count;
  logic [15:0] lfsr;
  sample_t     expected_q[$];

  always #2 clock = ~clock;

  // Pull-up; either side may pull the line low.
  assign line_in = !(line_drive_low || sensor_low);

  dht11_top dut_i (
    .clock          (clock),
    .reset          (reset),
    .wb_cyc         (wb_cyc),
    .wb_stb         (wb_stb),
    .wb_we          (wb_we),
    .wb_adr         (wb_adr),
    .wb_dat_w       (wb_dat_w),
    .wb_dat_r       (wb_dat_r),
    .wb_ack         (wb_ack),
    .line_drive_low (line_drive_low),
    .line_in        (line_in)
  );

  dht11_sensor_model sensor_i (
    .clock        (clock),
    .line         (line_in),
    .humidity     (humidity),
    .temperature  (temperature),
    .bad_attempts (bad_attempts),
    .silent       (silent),
    .clear_count  (clear_count),
    .pull_low     (sensor_low),
    .start_count  (start_count)
  );

  function automatic logic [15:0] lfsr_next(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
  endfunction

  task automatic take_bits(input int width, output logic [15:0] value);
    value = '0;
    for (int i = 0; i < width; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[14:0], lfsr[0]};
    end
  endtask

  function automatic logic [31:0] status_word(input logic busy, input logic failed,
                                              input int count);
    return {27'd0, 3'(count), failed, busy};
  endfunction

  function automatic sample_t expected_record(input logic [15:0] hum, input logic [15:0] temp,
                                              input int bad, input logic mute);
    sample_t record;
    if (mute || bad >= MAX_TRIES) begin
      record = '{humidity: '0, temperature: '0, failed: 1'b1};
    end else begin
      record = '{humidity: hum, temperature: temp, failed: 1'b0};
    end
    return record;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("ERROR %s: expected %h, actual %h", name, expected, actual);
      $display("Done: errors found");
      $fatal(1, "Stopping at the first error.");
    end
  endtask

  task automatic fail_wait(input string what);
    $display("Timeout: %s", what);
    $display("Done: errors found");
    $fatal(1, "Stopping after a timeout.");
  endtask

  task automatic bus_cycle(input logic we, input logic adr, input logic [31:0] wdata,
                           output logic [31:0] rdata);
    int waited = 0;
    @(posedge clock);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    do begin
      @(posedge clock);
      waited++;
      if (waited > ACK_LIMIT) fail_wait("the Wishbone acknowledge never came");
    end while (wb_ack !== 1'b1);
    check_value("ack latency", ACK_EDGES, waited);
    rdata = wb_dat_r;
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic read_word(input logic adr, output logic [31:0] value);
    bus_cycle(1'b0, adr, 32'd0, value);
  endtask

  task automatic request_measurement();
    logic [31:0] unused;
    bus_cycle(1'b1, ADDR_CONTROL, 32'd1, unused);
  endtask

  task automatic wait_not_busy();
    logic [31:0] status;
    int polls = 0;
    do begin
      read_word(ADDR_CONTROL, status);
      polls++;
      if (polls > POLL_LIMIT) fail_wait("busy never fell after a measurement request");
    end while (status[0] !== 1'b0);
  endtask

  task automatic setup_sensor(input logic [15:0] hum, input logic [15:0] temp,
                              input int bad, input logic mute);
    @(posedge clock);
    humidity     <= hum;
    temperature  <= temp;
    bad_attempts <= 3'(bad);
    silent       <= mute;
    clear_count  <= 1'b1;
    @(posedge clock);
    clear_count  <= 1'b0;
  endtask

  // Data read of the head record against the front of the queue.
  task automatic read_record(input string name);
    logic [31:0] word;
    sample_t expected;
    expected = expected_q.pop_front();
    read_word(ADDR_DATA, word);
    check_value({name, " data"}, {expected.humidity, expected.temperature}, word);
  endtask

  task automatic measure_once(input string name, input logic [15:0] hum,
                              input logic [15:0] temp, input int bad, input logic mute);
    logic [31:0] word;
    logic [15:0] order;
    logic failed;
    expected_q.push_back(expected_record(hum, temp, bad, mute));
    failed = expected_q[0].failed;
    setup_sensor(hum, temp, bad, mute);
    request_measurement();
    wait_not_busy();
    take_bits(1, order);
    if (order[0] || failed) begin
      read_word(ADDR_CONTROL, word);
      check_value({name, " status"}, status_word(1'b0, failed, 1), word);
      read_record(name);
    end else begin
      read_record(name);
      read_word(ADDR_CONTROL, word);
      check_value({name, " status"}, status_word(1'b0, 1'b0, 0), word);
    end
    check_value({name, " start pulses"}, failed ? MAX_TRIES : bad + 1, start_count);
  endtask

  task automatic fill_and_drain();
    logic [15:0] hum;
    logic [15:0] temp;
    logic [31:0] word;
    for (int i = 0; i <= FIFO_DEPTH; i++) begin
      take_bits(16, hum);
      take_bits(16, temp);
      expected_q.push_back(expected_record(hum, temp, 0, 1'b0));
      setup_sensor(hum, temp, 0, 1'b0);
      request_measurement();
      if (i < FIFO_DEPTH) begin
        wait_not_busy();
        read_word(ADDR_CONTROL, word);
        check_value("fill status", status_word(1'b0, 1'b0, i + 1), word);
      end
    end
    // The last record waits in the producer while the FIFO is full.
    for (int i = 0; i < HOLD_POLLS; i++) begin
      read_word(ADDR_CONTROL, word);
      check_value("full status", status_word(1'b1, 1'b0, FIFO_DEPTH), word);
      if (i == HOLD_POLLS / 2) request_measurement();
    end
    check_value("full start pulses", 1, start_count);
    read_record("first drain");
    read_word(ADDR_CONTROL, word);
    check_value("first drain status", status_word(1'b0, 1'b0, FIFO_DEPTH), word);
    while (expected_q.size() > 0) read_record("drain");
  endtask

  task automatic empty_reads(input string name);
    logic [31:0] word;
    read_word(ADDR_CONTROL, word);
    check_value({name, " status"}, 32'd0, word);
    read_word(ADDR_DATA, word);
    check_value({name, " data"}, 32'd0, word);
    read_word(ADDR_CONTROL, word);
    check_value({name, " status after read"}, 32'd0, word);
  endtask

  initial begin
    logic [15:0] hum;
    logic [15:0] temp;
    clock        = 1'b0;
    reset        = 1'b1;
    wb_cyc       = 1'b0;
    wb_stb       = 1'b0;
    wb_we        = 1'b0;
    wb_adr       = 1'b0;
    wb_dat_w     = 32'd0;
    humidity     = 16'd0;
    temperature  = 16'd0;
    bad_attempts = 3'd0;
    silent       = 1'b0;
    clear_count  = 1'b0;
    lfsr         = 16'd65;
    repeat (8) @(posedge clock);
    reset <= 1'b0;
    empty_reads("after reset");
    for (int i = 0; i < 4; i++) begin
      take_bits(16, hum);
      take_bits(16, temp);
      measure_once("clean", hum, temp, 0, 1'b0);
    end
    for (int bad = 1; bad < MAX_TRIES; bad++) begin
      take_bits(16, hum);
      take_bits(16, temp);
      measure_once("retry", hum, temp, bad, 1'b0);
    end
    for (int bad = MAX_TRIES; bad <= MAX_TRIES + 1; bad++) begin
      take_bits(16, hum);
      take_bits(16, temp);
      measure_once("exhausted", hum, temp, bad, 1'b0);
    end
    measure_once("silent", hum, temp, 0, 1'b1);
    fill_and_drain();
    empty_reads("end");
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
common/dht11_pkg.sv
common/sample_if.sv
dht11/dht11_control.sv
dht11/dht11_receiver.sv
dht11/dht11_interface.sv
verilog/sample_fifo.sv
verilog/wb_sensor_port.sv
verilog/dht11_top.sv
test/dht11_sensor_model.sv
test/dht11_tb.sv

// File: Bender.yml
package:
  name: dht11_sensor

sources:
  - files:
      - common/dht11_pkg.sv
      - common/sample_if.sv
      - dht11/dht11_control.sv
      - dht11/dht11_receiver.sv
      - dht11/dht11_interface.sv
      - verilog/sample_fifo.sv
      - verilog/wb_sensor_port.sv
      - verilog/dht11_top.sv
  - target: test
    files:
      - test/dht11_sensor_model.sv
      - test/dht11_tb.sv
